// ==== design/fetch_pkg.sv ====
package fetch_pkg;

  // Word geometry
  localparam int unsigned NB_WORD        = 32;  // PC and instruction width
  localparam int unsigned NB_BYTE_OFFSET = 2;   // Byte bits below the word index

  // Instruction memory
  localparam int unsigned N_WORDS      = 256;
  localparam int unsigned NB_WORD_ADDR = $clog2(N_WORDS);  // Index from PC[9:2]

  // Immediate fields supplied by decode
  localparam int unsigned NB_INM_I = 16;  // BEQ/BNE offset
  localparam int unsigned NB_INM_J = 26;  // J/JAL target field

  // J/JAL keeps the PC region bits above the shifted target field
  localparam int unsigned NB_PC_REGION = NB_WORD - NB_INM_J - NB_BYTE_OFFSET;

  // Sign bits prepended to the shifted branch offset
  localparam int unsigned NB_BRANCH_EXT = NB_WORD - NB_INM_I - NB_BYTE_OFFSET;

  // Sequential increment, one word
  localparam logic [NB_WORD-1:0] PC_STEP = NB_WORD'(4);

  // Bubble word driven while a taken jump or branch is flushed
  localparam logic [NB_WORD-1:0] NOP_WORD = '0;

  // Fetch controller states
  typedef enum logic [1:0] {
    ST_IDLE     = 2'b00,  // Waiting for a load request or a start
    ST_LOAD_ACK = 2'b01,  // Word written, waiting for the request to drop
    ST_RUN      = 2'b10   // Fetching
  } fetch_state_t;

endpackage

// ==== design/program_counter.sv ====
module program_counter (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_clear,     // Start of run
  input  logic                             i_step,      // End of a load handshake
  input  logic                             i_advance,   // Run fetch issued
  input  logic                             i_branch,
  input  logic                             i_jump_inm,
  input  logic                             i_jump_rs,
  input  logic [fetch_pkg::NB_INM_I-1:0]   i_inm_i,
  input  logic [fetch_pkg::NB_INM_J-1:0]   i_inm_j,
  input  logic [fetch_pkg::NB_WORD-1:0]    i_rs,
  output logic [fetch_pkg::NB_WORD-1:0]    o_pc
);

  import fetch_pkg::*;

  logic [NB_WORD-1:0] pc;
  logic [NB_WORD-1:0] pc_plus4;
  logic [NB_WORD-1:0] branch_offset;
  logic [NB_WORD-1:0] jump_target;
  logic [NB_WORD-1:0] pc_next;

  assign pc_plus4 = pc + PC_STEP;

  // Signed word offset, relative to the incremented PC
  assign branch_offset = {{NB_BRANCH_EXT{i_inm_i[NB_INM_I-1]}},
                          i_inm_i,
                          {NB_BYTE_OFFSET{1'b0}}};

  assign jump_target = {pc[NB_WORD-1 -: NB_PC_REGION],
                        i_inm_j,
                        {NB_BYTE_OFFSET{1'b0}}};

  always_comb begin
    case ({i_branch, i_jump_rs, i_jump_inm})
      3'b000:  pc_next = pc_plus4;                  // Sequential
      3'b001:  pc_next = jump_target;               // J/JAL
      3'b010:  pc_next = i_rs;                      // JR/JALR
      3'b100:  pc_next = pc_plus4 + branch_offset;  // BEQ/BNE taken
      default: pc_next = pc;                        // Conflicting selects
    endcase
  end

  // Clear wins over the load step, which wins over the run advance
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      pc <= '0;
    end else if (i_clear) begin
      pc <= '0;
    end else if (i_step) begin
      pc <= pc_plus4;  // Next load address
    end else if (i_advance) begin
      pc <= pc_next;
    end
  end

  assign o_pc = pc;

endmodule

// ==== design/instruction_memory.sv ====
module instruction_memory (
  input  logic                          i_clock,
  input  logic                          i_reset,  // Clears the read register only
  input  logic                          i_write,
  input  logic [fetch_pkg::NB_WORD-1:0] i_addr,   // Byte address
  input  logic [fetch_pkg::NB_WORD-1:0] i_data,
  input  logic                          i_read,
  output logic [fetch_pkg::NB_WORD-1:0] o_data
);

  import fetch_pkg::*;

  logic [NB_WORD-1:0]      mem [N_WORDS];
  logic [NB_WORD_ADDR-1:0] word_addr;

  // Upper address bits are ignored, so addresses wrap
  assign word_addr = i_addr[NB_BYTE_OFFSET +: NB_WORD_ADDR];

  always_ff @(posedge i_clock) begin
    if (i_write) begin
      mem[word_addr] <= i_data;
    end
  end

  // Registered read port
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_data <= '0;
    end else if (i_read) begin
      o_data <= mem[word_addr];  // Holds between reads
    end
  end

endmodule

// ==== design/fetch_control.sv ====
module fetch_control (
  input  logic i_clock,
  input  logic i_reset,
  input  logic i_load_req,
  input  logic i_start,
  input  logic i_stop,
  input  logic i_valid,
  output logic o_load_ack,
  output logic o_running,
  output logic o_pc_clear,
  output logic o_pc_step,
  output logic o_pc_advance,
  output logic o_mem_write,
  output logic o_mem_read,
  output logic o_instr_valid
);

  import fetch_pkg::*;

  fetch_state_t state;
  fetch_state_t state_next;

  always_comb begin
    state_next   = state;
    o_pc_clear   = 1'b0;
    o_pc_step    = 1'b0;
    o_pc_advance = 1'b0;
    o_mem_write  = 1'b0;
    o_mem_read   = 1'b0;

    case (state)
      ST_IDLE: begin
        if (i_load_req) begin
          o_mem_write = 1'b1;         // Word lands at the current PC
          state_next  = ST_LOAD_ACK;
        end else if (i_start) begin
          o_pc_clear = 1'b1;          // Run always begins at address 0
          state_next = ST_RUN;
        end
      end

      // Handshake open, start is not looked at here
      ST_LOAD_ACK: begin
        if (!i_load_req) begin
          o_pc_step  = 1'b1;
          state_next = ST_IDLE;
        end
      end

      ST_RUN: begin
        if (i_stop) begin
          state_next = ST_IDLE;       // No fetch issued on the stop cycle
        end else if (i_valid) begin
          o_mem_read   = 1'b1;
          o_pc_advance = 1'b1;
        end
      end

      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // One cycle behind each issued read, so at most one fetch in flight
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_instr_valid <= 1'b0;
    end else begin
      o_instr_valid <= o_mem_read;
    end
  end

  assign o_load_ack = (state == ST_LOAD_ACK);
  assign o_running  = (state == ST_RUN);

endmodule

// ==== design/fetch_stage.sv ====
module fetch_stage (
  input  logic                           i_clock,
  input  logic                           i_reset,
  input  logic                           i_load_req,
  input  logic [fetch_pkg::NB_WORD-1:0]  i_load_data,
  output logic                           o_load_ack,
  input  logic                           i_start,
  input  logic                           i_stop,
  input  logic                           i_valid,
  input  logic                           i_branch,
  input  logic                           i_jump_inm,
  input  logic                           i_jump_rs,
  input  logic [fetch_pkg::NB_INM_I-1:0] i_inm_i,
  input  logic [fetch_pkg::NB_INM_J-1:0] i_inm_j,
  input  logic [fetch_pkg::NB_WORD-1:0]  i_rs,
  input  logic                           i_flush,   // Taken jump or branch upstream
  output logic [fetch_pkg::NB_WORD-1:0]  o_pc,
  output logic [fetch_pkg::NB_WORD-1:0]  o_instruction,
  output logic                           o_instr_valid,
  output logic                           o_running
);

  import fetch_pkg::*;

  logic               pc_clear;
  logic               pc_step;
  logic               pc_advance;
  logic               mem_write;
  logic               mem_read;
  logic [NB_WORD-1:0] pc;
  logic [NB_WORD-1:0] mem_data;

  fetch_control u_fetch_control (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_load_req    (i_load_req),
    .i_start       (i_start),
    .i_stop        (i_stop),
    .i_valid       (i_valid),
    .o_load_ack    (o_load_ack),
    .o_running     (o_running),
    .o_pc_clear    (pc_clear),
    .o_pc_step     (pc_step),
    .o_pc_advance  (pc_advance),
    .o_mem_write   (mem_write),
    .o_mem_read    (mem_read),
    .o_instr_valid (o_instr_valid)
  );

  program_counter u_program_counter (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_clear    (pc_clear),
    .i_step     (pc_step),
    .i_advance  (pc_advance),
    .i_branch   (i_branch),
    .i_jump_inm (i_jump_inm),
    .i_jump_rs  (i_jump_rs),
    .i_inm_i    (i_inm_i),
    .i_inm_j    (i_inm_j),
    .i_rs       (i_rs),
    .o_pc       (pc)
  );

  instruction_memory u_instruction_memory (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_write (mem_write),
    .i_addr  (pc),         // Write address while loading, fetch address in run
    .i_data  (i_load_data),
    .i_read  (mem_read),
    .o_data  (mem_data)
  );

  // Address of the word now in the memory read register
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_pc <= '0;
    end else if (mem_read) begin
      o_pc <= pc;
    end
  end

  assign o_instruction = i_flush ? NOP_WORD : mem_data;  // Bubble on flush

endmodule

// ==== verification/fetch_stage_asserts.sv ====
module fetch_stage_asserts (
  input logic                    i_clock,
  input logic                    i_reset,
  input logic                    i_load_req,
  input logic                    i_load_ack,
  input logic                    i_instr_valid,
  input fetch_pkg::fetch_state_t i_state
);

  timeunit 1ns;
  timeprecision 100ps;

  import fetch_pkg::*;

  // The acknowledge only answers a request seen at the previous edge
  ack_needs_req: assert property (
    @(posedge i_clock) disable iff (i_reset)
      $rose(i_load_ack) |-> $past(i_load_req)
  ) else $error("o_load_ack rose without i_load_req");

  ack_held_for_req: assert property (
    @(posedge i_clock) disable iff (i_reset)
      (i_load_ack && i_load_req) |=> i_load_ack  // Falls only once the request is gone
  ) else $error("o_load_ack dropped while i_load_req was high");

  valid_after_run: assert property (
    @(posedge i_clock) disable iff (i_reset)
      i_instr_valid |-> ($past(i_state) == ST_RUN)
  ) else $error("o_instr_valid high without a run cycle before it");

endmodule

// ==== verification/fetch_stage_tb.sv ====
module fetch_stage_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fetch_pkg::*;

  localparam int unsigned HALF_PERIOD     = 20;   // 40 ns clock
  localparam int unsigned CYCLES_PER_LINE = 200;  // Watchdog budget per trace line
  localparam string       TRACE_FILE      = "verification/fetch_trace.txt";

  logic                i_clock;
  logic                i_reset;
  logic                i_load_req;
  logic [NB_WORD-1:0]  i_load_data;
  logic                o_load_ack;
  logic                i_start;
  logic                i_stop;
  logic                i_valid;
  logic                i_branch;
  logic                i_jump_inm;
  logic                i_jump_rs;
  logic [NB_INM_I-1:0] i_inm_i;
  logic [NB_INM_J-1:0] i_inm_j;
  logic [NB_WORD-1:0]  i_rs;
  logic                i_flush;
  logic [NB_WORD-1:0]  o_pc;
  logic [NB_WORD-1:0]  o_instruction;
  logic                o_instr_valid;
  logic                o_running;

  logic [NB_WORD-1:0] model_mem [N_WORDS];  // Words the host has loaded
  logic [NB_WORD-1:0] model_pc;             // Expected DUT PC at the next edge
  string              trace_q [$];
  int                 trace_lines;
  int                 error_count;

  fetch_stage fetch_stage_inst (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_load_req    (i_load_req),
    .i_load_data   (i_load_data),
    .o_load_ack    (o_load_ack),
    .i_start       (i_start),
    .i_stop        (i_stop),
    .i_valid       (i_valid),
    .i_branch      (i_branch),
    .i_jump_inm    (i_jump_inm),
    .i_jump_rs     (i_jump_rs),
    .i_inm_i       (i_inm_i),
    .i_inm_j       (i_inm_j),
    .i_rs          (i_rs),
    .i_flush       (i_flush),
    .o_pc          (o_pc),
    .o_instruction (o_instruction),
    .o_instr_valid (o_instr_valid),
    .o_running     (o_running)
  );

  bind fetch_stage fetch_stage_asserts u_fetch_stage_asserts (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_load_req    (i_load_req),
    .i_load_ack    (o_load_ack),
    .i_instr_valid (o_instr_valid),
    .i_state       (u_fetch_control.state)
  );

  always #(HALF_PERIOD) i_clock = ~i_clock;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped");
  endtask

  // Next fetch address from the select bits and operands
  function automatic logic [NB_WORD-1:0] next_address(
    input logic [NB_WORD-1:0]  pc,
    input int                  branch,
    input int                  jump_inm,
    input int                  jump_rs,
    input logic [NB_INM_I-1:0] inm_i,
    input logic [NB_INM_J-1:0] inm_j,
    input logic [NB_WORD-1:0]  rs
  );
    int offset;
    offset = int'($signed(inm_i)) * 4;  // Byte offset, may be negative
    if (branch + jump_inm + jump_rs > 1) begin
      return pc;
    end else if (jump_inm != 0) begin
      return {pc[31:28], inm_j, 2'b00};
    end else if (jump_rs != 0) begin
      return rs;
    end else if (branch != 0) begin
      return pc + 32'd4 + 32'(offset);
    end
    return pc + 32'd4;
  endfunction

  task automatic clear_run_inputs();
    i_valid    = 1'b0;
    i_branch   = 1'b0;
    i_jump_inm = 1'b0;
    i_jump_rs  = 1'b0;
    i_inm_i    = '0;
    i_inm_j    = '0;
    i_rs       = '0;
    i_flush    = 1'b0;
  endtask

  task automatic read_trace();
    int    fd;
    int    status;
    string line;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the trace file");
    end
    while (!$feof(fd)) begin
      line = "";
      status = $fgets(line, fd);
      if (status != 0 && line.len() > 1 && line.getc(0) != "#") begin
        trace_q.push_back(line);  // Comment and blank lines dropped
      end
    end
    $fclose(fd);
    if (trace_q.size() == 0) begin
      abort_run("The trace file holds no commands");
    end
    trace_lines = trace_q.size();
  endtask

  // One four-phase handshake with random gaps
  task automatic load_word(input logic [NB_WORD-1:0] word);
    int unsigned gap;
    int          cycles;
    gap = $urandom_range(3, 0);
    repeat (gap) @(negedge i_clock);
    assert (o_load_ack == 1'b0) else report_mismatch("o_load_ack high before a request");
    i_load_data = word;
    i_load_req  = 1'b1;
    cycles = 0;
    do begin
      @(negedge i_clock);
      cycles++;
    end while (!o_load_ack && cycles < 4);
    assert (o_load_ack && cycles == 1)
      else report_mismatch($sformatf("o_load_ack rose after %0d cycles, expected 1", cycles));
    model_mem[model_pc[9:2]] = word;
    gap = $urandom_range(3, 0);
    repeat (gap) begin
      @(negedge i_clock);
      assert (o_load_ack) else report_mismatch("o_load_ack dropped while i_load_req was high");
    end
    i_load_req = 1'b0;
    cycles = 0;
    do begin
      @(negedge i_clock);
      cycles++;
    end while (o_load_ack && cycles < 4);
    assert (!o_load_ack && cycles == 1)
      else report_mismatch($sformatf("o_load_ack fell after %0d cycles, expected 1", cycles));
    model_pc = model_pc + 32'd4;  // PC steps at the drop
  endtask

  task automatic start_run();
    clear_run_inputs();
    i_start = 1'b1;
    @(negedge i_clock);
    i_start  = 1'b0;
    model_pc = '0;
    assert (o_running && !o_instr_valid)
      else report_mismatch("o_running not high one cycle after i_start");
  endtask

  // Valid stays high on the stop cycle, which must issue no fetch
  task automatic stop_run();
    clear_run_inputs();
    i_valid = 1'b1;
    i_stop  = 1'b1;
    @(negedge i_clock);
    i_stop  = 1'b0;
    i_valid = 1'b0;
    assert (!o_running && !o_instr_valid)
      else report_mismatch("Stage still running or valid after i_stop");
  endtask

  task automatic run_cycle(input string line);
    string               cmd;
    int                  fields;
    int                  valid;
    int                  branch;
    int                  jump_inm;
    int                  jump_rs;
    int                  flush;
    logic [NB_INM_I-1:0] inm_i;
    logic [NB_INM_J-1:0] inm_j;
    logic [NB_WORD-1:0]  rs;
    logic [NB_WORD-1:0]  trace_pc;
    logic [NB_WORD-1:0]  trace_instr;
    logic [NB_WORD-1:0]  exp_pc;
    logic [NB_WORD-1:0]  exp_instr;
    fields = $sscanf(line, "%s %d %d %d %d %h %h %h %d %h %h", cmd, valid, branch,
                     jump_inm, jump_rs, inm_i, inm_j, rs, flush, trace_pc, trace_instr);
    if (fields != 11) begin
      abort_run($sformatf("Malformed run line in the trace: %s", line));
    end
    i_valid    = valid[0];
    i_branch   = branch[0];
    i_jump_inm = jump_inm[0];
    i_jump_rs  = jump_rs[0];
    i_inm_i    = inm_i;
    i_inm_j    = inm_j;
    i_rs       = rs;
    i_flush    = flush[0];
    exp_pc    = model_pc;
    exp_instr = (flush != 0) ? 32'd0 : model_mem[model_pc[9:2]];
    if (valid != 0) begin
      model_pc = next_address(model_pc, branch, jump_inm, jump_rs, inm_i, inm_j, rs);
    end
    @(negedge i_clock);  // Fetch issued at the rising edge in between
    assert (o_running) else report_mismatch("o_running low during a run");
    assert (o_instr_valid == valid[0])
      else report_mismatch($sformatf("o_instr_valid %0b, expected %0b",
                                     o_instr_valid, valid[0]));
    if (valid != 0) begin
      assert (trace_pc == exp_pc && trace_instr == exp_instr)
        else report_mismatch($sformatf("Trace expects %h/%h, model gives %h/%h",
                                       trace_pc, trace_instr, exp_pc, exp_instr));
      assert (o_pc == exp_pc)
        else report_mismatch($sformatf("o_pc %h, expected %h", o_pc, exp_pc));
      assert (o_instruction == exp_instr)
        else report_mismatch($sformatf("o_instruction %h, expected %h",
                                       o_instruction, exp_instr));
    end
  endtask

  initial begin
    string              line;
    string              cmd;
    int                 fields;
    int                 count;
    logic [NB_WORD-1:0] word;

    i_clock     = 1'b0;
    i_reset     = 1'b1;
    i_load_req  = 1'b0;
    i_load_data = '0;
    i_start     = 1'b0;
    i_stop      = 1'b0;
    clear_run_inputs();
    error_count = 0;
    trace_lines = 0;
    model_pc    = '0;
    void'($urandom(32'h2ca5));
    read_trace();

    repeat (4) @(posedge i_clock);
    @(negedge i_clock);
    i_reset = 1'b0;
    assert (!o_load_ack && !o_instr_valid && !o_running)
      else report_mismatch("Outputs not low after reset");

    while (trace_q.size() > 0) begin
      line   = trace_q.pop_front();
      fields = $sscanf(line, "%s", cmd);
      if (cmd == "load") begin
        fields = $sscanf(line, "%s %d", cmd, count);
        if (fields != 2 || count > trace_q.size()) begin
          abort_run($sformatf("Malformed load line in the trace: %s", line));
        end
        repeat (count) begin
          line   = trace_q.pop_front();
          fields = $sscanf(line, "%h", word);
          if (fields != 1) begin
            abort_run($sformatf("Malformed program word in the trace: %s", line));
          end
          load_word(word);
        end
      end else if (cmd == "start") begin
        start_run();
      end else if (cmd == "stop") begin
        stop_run();
      end else if (cmd == "run") begin
        run_cycle(line);
      end else begin
        abort_run($sformatf("Unknown command in the trace: %s", line));
      end
    end

    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog sized from the trace length
  initial begin
    wait (trace_lines != 0);
    #(trace_lines * CYCLES_PER_LINE * 2 * HALF_PERIOD);
    abort_run("Timeout: the trace did not finish in the allowed time");
  end

endmodule

// ==== verification/fetch_trace.txt ====
# Commands: "load <count>" then <count> hex words, "start", "stop", or a run line
# run valid branch jump_inm jump_rs inm_i inm_j rs flush exp_pc exp_instr (exp unused at valid 0)
load 16
20080001
20090002
01095020
0800000A
1109FFFC
8C0B0004
AC0B0008
00A63020
03E00008
11290002
012A5822
0C000003
3C0C1234
358C5678
018D7025
1000FFF0
start
run 1 0 0 0 0000 0000000 00000000 0 00000000 20080001
run 1 0 0 0 0000 0000000 00000000 0 00000004 20090002
run 1 0 0 0 0000 0000000 00000000 0 00000008 01095020
run 0 0 0 0 0000 0000000 00000000 0 00000000 00000000
run 0 0 0 0 0000 0000000 00000000 0 00000000 00000000
run 1 0 0 0 0000 0000000 00000000 0 0000000C 0800000A
run 1 0 1 0 0000 0000009 00000000 0 00000010 1109FFFC
run 1 0 0 0 0000 0000000 00000000 1 00000024 00000000
run 1 1 0 0 0002 0000000 00000000 0 00000028 012A5822
run 1 0 0 0 0000 0000000 00000000 0 00000034 358C5678
run 1 1 0 0 FFF9 0000000 00000000 0 00000038 018D7025
run 1 0 0 0 0000 0000000 00000000 0 00000020 03E00008
run 1 1 1 0 0001 0000001 00000000 0 00000024 11290002
run 1 0 0 0 0000 0000000 00000000 0 00000024 11290002
run 1 1 1 1 0001 0000001 00000100 0 00000028 012A5822
run 1 0 0 1 0000 0000000 00000030 0 00000028 012A5822
run 1 0 0 0 0000 0000000 00000000 1 00000030 00000000
run 0 0 0 0 0000 0000000 00000000 0 00000000 00000000
run 1 0 0 0 0000 0000000 00000000 0 00000034 358C5678
run 1 0 0 1 0000 0000000 10000004 0 00000038 018D7025
run 1 0 0 0 0000 0000000 00000000 0 10000004 20090002
run 1 0 1 0 0000 0000003 00000000 0 10000008 01095020
run 1 0 0 0 0000 0000000 00000000 0 1000000C 0800000A
run 1 1 0 0 FFFB 0000000 00000000 0 10000010 1109FFFC
run 1 0 0 0 0000 0000000 00000000 0 10000000 20080001
run 1 0 0 1 0000 0000000 00000400 0 10000004 20090002
stop
load 3
24100007
24110008
02119020
start
run 1 0 0 0 0000 0000000 00000000 0 00000000 24100007
run 1 0 0 0 0000 0000000 00000000 0 00000004 24110008
run 1 0 0 0 0000 0000000 00000000 0 00000008 02119020
run 1 0 0 0 0000 0000000 00000000 0 0000000C 0800000A
stop

// ==== build.f ====
design/fetch_pkg.sv
design/program_counter.sv
design/instruction_memory.sv
design/fetch_control.sv
design/fetch_stage.sv
verification/fetch_stage_asserts.sv
verification/fetch_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module fetch_stage_tb \
  -f build.f \
  --Mdir "$BUILD_DIR" -o fetch_stage_sim

# The log decides the result, so a nonzero exit here does not stop the script
"./$BUILD_DIR/fetch_stage_sim" 2>&1 | tee "$LOG_FILE"

if grep -q "Some tests failed" "$LOG_FILE"; then
  echo "Simulation reported a failure, see $LOG_FILE"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG_FILE"; then
  echo "Simulation ended without a result, see $LOG_FILE"
  exit 1
fi
